//--- verilog/alu_pkg.sv
package alu_pkg;

	// Datapath width, fixed by the instruction set
	localparam int word_w = 32;

	// Opcode encodings of the execution unit
	localparam logic [4:0] ld_op   = 5'b00000;
	localparam logic [4:0] ldi_op  = 5'b00001;
	localparam logic [4:0] st_op   = 5'b00010;
	localparam logic [4:0] add_op  = 5'b00011;
	localparam logic [4:0] sub_op  = 5'b00100;
	localparam logic [4:0] shr_op  = 5'b00101; // Logical right
	localparam logic [4:0] shra_op = 5'b00110; // Arithmetic right
	localparam logic [4:0] shl_op  = 5'b00111;
	localparam logic [4:0] ror_op  = 5'b01000;
	localparam logic [4:0] rol_op  = 5'b01001;
	localparam logic [4:0] and_op  = 5'b01010;
	localparam logic [4:0] or_op   = 5'b01011;
	localparam logic [4:0] addi_op = 5'b01100;
	localparam logic [4:0] andi_op = 5'b01101;
	localparam logic [4:0] ori_op  = 5'b01110;
	localparam logic [4:0] mul_op  = 5'b01111;
	localparam logic [4:0] div_op  = 5'b10000;
	localparam logic [4:0] neg_op  = 5'b10001;
	localparam logic [4:0] not_op  = 5'b10010;
	// Encodings 19 to 31 are undefined and give zero

	// One operation as both units see it
	typedef struct packed {
		logic [4:0]        op;
		logic [word_w-1:0] a;  // From Y
		logic [word_w-1:0] b;  // From the bus
	} alu_req_t;

	// Product view of a 64-bit result
	typedef struct packed {
		logic [word_w-1:0] hi;
		logic [word_w-1:0] lo;
	} prod_t;

	// Division view of the same word
	typedef struct packed {
		logic [word_w-1:0] rem; // Upper word
		logic [word_w-1:0] quo; // Lower word
	} divres_t;

	// Result word, read as a product or as a quotient with remainder
	typedef union packed {
		prod_t   prod;
		divres_t dres;
	} alu_word_u;

endpackage

//--- verilog/logic_shift_unit.sv
`timescale 1ns/10ps

module logic_shift_unit
	import alu_pkg::*;
(
	input  alu_req_t          req,
	output logic [word_w-1:0] res
);

	logic [4:0]          amt;       // Shift and rotate amount
	logic [word_w-1:0]   sum;
	logic [word_w-1:0]   diff;
	logic [word_w-1:0]   and_res;
	logic [word_w-1:0]   or_res;
	logic [word_w-1:0]   shr_res;
	logic [word_w-1:0]   shra_res;
	logic [word_w-1:0]   shl_res;
	logic [2*word_w-1:0] dbl;       // Operand a placed twice for rotates
	logic [2*word_w-1:0] ror_dbl;
	logic [2*word_w-1:0] rol_dbl;
	logic [word_w-1:0]   ror_res;
	logic [word_w-1:0]   rol_res;
	logic [word_w-1:0]   neg_res;
	logic [word_w-1:0]   not_res;

	assign amt = req.b[4:0];

	// Adder and subtractor, carry out is not kept
	assign sum  = req.a + req.b;
	assign diff = req.a - req.b;

	assign and_res = req.a & req.b;
	assign or_res  = req.a | req.b;

	// Shifts of a by the low five bits of b
	assign shr_res  = req.a >> amt;
	assign shra_res = $signed(req.a) >>> amt;
	assign shl_res  = req.a << amt;

	// A rotate is a shift of the doubled word, then one half is taken
	assign dbl     = {req.a, req.a};
	assign ror_dbl = dbl >> amt;
	assign rol_dbl = dbl << amt;
	assign ror_res = ror_dbl[word_w-1:0];   // Bits wrapped in from the top copy
	assign rol_res = rol_dbl[2*word_w-1:word_w];

	// Unary operations work on b only
	assign neg_res = ~req.b + 1'b1;       // Two's complement
	assign not_res = ~req.b;

	always_comb begin
		res = '0; // Opcodes not handled here
		case (req.op)
			ld_op, ldi_op, st_op,
			add_op, addi_op: begin
				res = sum; // Loads and stores form an address
			end
			sub_op: begin
				res = diff;
			end
			and_op, andi_op: begin
				res = and_res;
			end
			or_op, ori_op: begin
				res = or_res;
			end
			shr_op: begin
				res = shr_res;
			end
			shra_op: begin
				res = shra_res;
			end
			shl_op: begin
				res = shl_res;
			end
			ror_op: begin
				res = ror_res;
			end
			rol_op: begin
				res = rol_res;
			end
			neg_op: begin
				res = neg_res;
			end
			not_op: begin
				res = not_res;
			end
			default: begin
				res = '0;
			end
		endcase
	end

endmodule

//--- verilog/mul_div_unit.sv
`timescale 1ns/10ps

module mul_div_unit
	import alu_pkg::*;
(
	input  alu_req_t  req,
	output alu_word_u res
);

	logic signed [word_w-1:0]   a_s;
	logic signed [word_w-1:0]   b_s;
	logic signed [2*word_w-1:0] prod_full; // Full signed product

	logic                       div_zero;  // Divisor is zero
	logic                       div_ovf;   // Most negative over minus one
	logic signed [word_w-1:0]   den_s;     // Divisor handed to the divider
	logic signed [word_w-1:0]   quo_raw;
	logic signed [word_w-1:0]   rem_raw;
	logic [word_w-1:0]          quo;
	logic [word_w-1:0]          rem;

	assign a_s = $signed(req.a);
	assign b_s = $signed(req.b);

	// Operands are sign extended to 64 bits before the multiply
	assign prod_full = a_s * b_s;

	// Cases the division operator must not see
	assign div_zero = (req.b == '0);
	assign div_ovf  = (req.a == {1'b1, {(word_w-1){1'b0}}}) && (&req.b);

	// Substitute one as divisor so both special cases stay defined
	always_comb begin
		if (div_zero || div_ovf) begin
			den_s = 1;
		end else begin
			den_s = b_s;
		end
	end

	// Truncates toward zero, remainder follows the sign of a
	assign quo_raw = a_s / den_s;
	assign rem_raw = a_s % den_s;

	// Fix up the special results
	always_comb begin
		quo = quo_raw;
		rem = rem_raw;
		if (div_zero) begin
			quo = '1;       // All ones
			rem = req.a;
		end else if (div_ovf) begin
			quo = req.a;    // a over 1 already gives this
			rem = '0;
		end
	end

	always_comb begin
		res = '0;
		case (req.op)
			mul_op: begin
				res.prod.hi = prod_full[2*word_w-1:word_w];
				res.prod.lo = prod_full[word_w-1:0];
			end
			div_op: begin
				res.dres.rem = rem;
				res.dres.quo = quo;
			end
			default: begin
				res = '0; // Not a multiply or divide
			end
		endcase
	end

endmodule

//--- verilog/result_merge.sv
`timescale 1ns/10ps

module result_merge
	import alu_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n,
	input  logic [4:0]        op,
	input  logic [word_w-1:0] lsu_res,
	input  alu_word_u         mdu_res,
	output alu_word_u         c
);

	logic      is_md;   // Multiply or divide, full 64-bit result
	logic      is_word; // 32-bit operation
	alu_word_u c_next;

	// Opcode class
	always_comb begin
		is_md   = 1'b0;
		is_word = 1'b0;
		case (op)
			mul_op, div_op: begin
				is_md = 1'b1;
			end
			ld_op, ldi_op, st_op, add_op, addi_op, sub_op,
			shr_op, shra_op, shl_op, ror_op, rol_op,
			and_op, andi_op, or_op, ori_op,
			neg_op, not_op: begin
				is_word = 1'b1;
			end
			default: begin
				is_md   = 1'b0; // Undefined opcode
				is_word = 1'b0;
			end
		endcase
	end

	// Select the unit, zero extending 32-bit results
	always_comb begin
		if (is_md) begin
			c_next = mdu_res;
		end else if (is_word) begin
			c_next = alu_word_u'({{word_w{1'b0}}, lsu_res});
		end else begin
			c_next = '0;
		end
	end

	// Single register stage, one cycle from inputs to c
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			c <= '0;
		end else begin
			c <= c_next;
		end
	end

endmodule

//--- verilog/alu_top.sv
`timescale 1ns/10ps

module alu_top
	import alu_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n,
	input  logic [4:0]        op_code,
	input  logic [word_w-1:0] a,       // From Y
	input  logic [word_w-1:0] b,       // From the bus
	output alu_word_u         c
);

	alu_req_t          req;
	logic [word_w-1:0] lsu_res;
	alu_word_u         mdu_res;

	assign req = '{op: op_code, a: a, b: b};

	// Both units work on the same request side by side
	logic_shift_unit u_lsu (
		.req (req),
		.res (lsu_res)
	);

	mul_div_unit u_mdu (
		.req (req),
		.res (mdu_res)
	);

	// Picks by opcode class and registers the result
	result_merge u_merge (
		.clk     (clk),
		.rst_n   (rst_n),
		.op      (req.op),
		.lsu_res (lsu_res),
		.mdu_res (mdu_res),
		.c       (c)
	);

endmodule

//--- verif/alu_properties.sv
`timescale 1ns/10ps

module alu_properties
	import alu_pkg::*;
(
	input logic              clk,
	input logic              rst_n,
	input logic [4:0]        op_code,
	input logic [word_w-1:0] a,
	input logic [word_w-1:0] b,
	input alu_word_u         c
);

	// Failure counts that the testbench reads at the end of the run
	int rst_fails   = 0;
	int upper_fails = 0;
	int undef_fails = 0;
	int dzero_fails = 0;
	int ovf_fails   = 0;

	logic is_word_op; // Defined opcode with a 32-bit result

	assign is_word_op = (op_code <= not_op) && (op_code != mul_op) && (op_code != div_op);

	// Clear during reset and on the first edge after release
	reset_clear: assert property (@(posedge clk) !rst_n |=> (c == '0))
		else begin
			$error("c is not zero during or right after reset");
			rst_fails++;
		end

	upper_zero: assert property (@(posedge clk)
		(rst_n && is_word_op) |=> (!rst_n || c.prod.hi == '0))
		else begin
			$error("Upper word of c is not zero after a 32-bit operation");
			upper_fails++;
		end

	// Opcodes 19 to 31
	undef_zero: assert property (@(posedge clk)
		(rst_n && op_code > not_op) |=> (!rst_n || c == '0))
		else begin
			$error("c is not zero after an undefined opcode");
			undef_fails++;
		end

	div_by_zero: assert property (@(posedge clk)
		(rst_n && op_code == div_op && b == '0)
		|=> (!rst_n || (c.dres.quo == '1 && c.dres.rem == $past(a))))
		else begin
			$error("Divide by zero did not give all ones and the dividend");
			dzero_fails++;
		end

	div_overflow: assert property (@(posedge clk)
		(rst_n && op_code == div_op && a == 32'h8000_0000 && b == '1)
		|=> (!rst_n || (c.dres.quo == 32'h8000_0000 && c.dres.rem == '0)))
		else begin
			$error("Most negative over minus one gave a wrong quotient or remainder");
			ovf_fails++;
		end

endmodule

//--- verif/alu_tb.sv
`timescale 1ns/10ps

module alu_tb
	import alu_pkg::*;
();

	logic              clk;
	logic              rst_n;
	logic [4:0]        op_code;
	logic [word_w-1:0] a;
	logic [word_w-1:0] b;
	alu_word_u         c;
	logic [63:0]       c_word;

	logic [31:0] lfsr = 32'h991e108d;
	logic [63:0] exp_c;             // Expected c for the operands now on the inputs
	logic        exp_valid = 1'b0;
	int          errors = 0;
	int          checks = 0;
	int          prop_fails = 0;
	int          cycles = 0;
	int          cycle_limit;
	int          n_directed = 50;   // Upper bound of the directed phase
	int          n_random = 400;

	alu_top uut (
		.clk     (clk),
		.rst_n   (rst_n),
		.op_code (op_code),
		.a       (a),
		.b       (b),
		.c       (c)
	);

	bind alu_top alu_properties props (
		.clk     (clk),
		.rst_n   (rst_n),
		.op_code (op_code),
		.a       (a),
		.b       (b),
		.c       (c)
	);

	assign c_word = c;

	always #4 clk = ~clk;

	// Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// Signed division through magnitudes returning {remainder, quotient}
	function automatic logic [63:0] div_model(input logic [31:0] x, input logic [31:0] y);
		logic [31:0] mx;
		logic [31:0] my;
		logic [31:0] q;
		logic [31:0] rm;
		if (y == 32'd0) begin
			return {x, 32'hffff_ffff};
		end
		if (x == 32'h8000_0000 && y == 32'hffff_ffff) begin
			return {32'd0, x};
		end
		mx = x[31] ? 32'd0 - x : x;
		my = y[31] ? 32'd0 - y : y;
		q  = mx / my;
		rm = mx % my;
		if (x[31] ^ y[31]) begin
			q = 32'd0 - q;
		end
		if (x[31]) begin
			rm = 32'd0 - rm; // Remainder keeps the dividend's sign
		end
		return {rm, q};
	endfunction

	function automatic logic [63:0] model_c(input logic [4:0] op, input logic [31:0] x,
		input logic [31:0] y);
		logic [4:0]  n;
		logic [63:0] r;
		n = y[4:0];
		r = '0;
		case (op)
			ld_op, ldi_op, st_op, add_op, addi_op: r[31:0] = x + y;
			sub_op:          r[31:0] = x - y;
			and_op, andi_op: r[31:0] = x & y;
			or_op, ori_op:   r[31:0] = x | y;
			shr_op:          r[31:0] = x >> n;
			shra_op:         r[31:0] = (x >> n) | (x[31] ? ~(32'hffff_ffff >> n) : 32'd0);
			shl_op:          r[31:0] = x << n;
			ror_op:          r[31:0] = (x >> n) | (x << (32 - n)); // n = 0 shifts by 32
			rol_op:          r[31:0] = (x << n) | (x >> (32 - n));
			neg_op:          r[31:0] = 32'd0 - y;
			not_op:          r[31:0] = ~y;
			mul_op:          r = $signed({{32{x[31]}}, x}) * $signed({{32{y[31]}}, y});
			div_op:          r = div_model(x, y);
			default:         r = '0;
		endcase
		return r;
	endfunction

	// Checks the previous operation, then records the one now on the inputs
	always @(negedge clk) begin
		logic [63:0] want;
		want = rst_n ? exp_c : 64'd0;
		if (exp_valid) begin
			checks++;
			assert (c_word === want) else begin
				errors++;
				$display("ERROR at %0d ns: c expected %h got %h", $time, want, c_word);
			end
		end
		exp_c = rst_n ? model_c(op_code, a, b) : 64'd0;
		exp_valid = 1'b1;
	end

	task automatic report_counts();
		prop_fails = uut.props.rst_fails + uut.props.upper_fails + uut.props.undef_fails
			+ uut.props.dzero_fails + uut.props.ovf_fails;
		$display("Checks %0d, value errors %0d, property failures %0d",
			checks, errors, prop_fails);
	endtask

	always @(posedge clk) begin
		cycles++;
		if (cycles > cycle_limit) begin
			$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
			report_counts();
			$display("RESULT: FAIL");
			$finish;
		end
	end

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	task automatic issue(input logic [4:0] op, input logic [31:0] x, input logic [31:0] y);
		@(posedge clk);
		op_code <= op;
		a       <= x;
		b       <= y;
	endtask

	task automatic pulse_reset();
		@(posedge clk);
		rst_n <= 1'b0;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
	endtask

	task automatic directed_ops();
		issue(div_op, 32'd5, 32'd0);                  // Divide by zero
		issue(div_op, 32'hffff_fff9, 32'd0);
		issue(div_op, 32'd0, 32'd0);
		issue(div_op, 32'h8000_0000, 32'd0);
		issue(div_op, 32'h8000_0000, 32'hffff_ffff);  // Overflow case
		issue(div_op, 32'd7, 32'd2);
		issue(div_op, 32'hffff_fff9, 32'd2);
		issue(div_op, 32'd7, 32'hffff_fffe);
		issue(div_op, 32'hffff_fff9, 32'hffff_fffe);
		issue(div_op, 32'h8000_0000, 32'd2);
		issue(mul_op, 32'h8000_0000, 32'h8000_0000);
		// Shifts and rotates at both ends of the amount range
		for (int op = shr_op; op <= rol_op; op++) begin
			issue(5'(op), 32'h8000_0001, 32'd0);
			issue(5'(op), 32'h8000_0001, 32'd31);
		end
		issue(ror_op, 32'h1234_5678, 32'h0000_0023); // Only b[4:0] counts
		for (int op = 0; op <= not_op; op++) begin
			issue(5'(op), 32'hffff_ffff, 32'hffff_ffff);
		end
		issue(add_op, 32'd0, 32'd0);
		issue(5'd19, 32'hffff_ffff, 32'hffff_ffff);
		issue(5'd31, 32'h1234_5678, 32'h9abc_def0);
	endtask

	task automatic random_ops();
		logic [31:0] ra;
		logic [31:0] rb;
		logic [31:0] ro;
		for (int i = 0; i < n_random; i++) begin
			take_bits(32, ra);
			take_bits(32, rb);
			take_bits(5, ro);
			if (i == n_random / 2) begin
				pulse_reset();
			end
			issue(ro[4:0], ra, rb);
		end
	endtask

	initial begin
		clk         = 1'b0;
		rst_n       = 1'b0;
		op_code     = '0;
		a           = '0;
		b           = '0;
		cycle_limit = n_directed + n_random + 150; // Reset, drain and margin
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		directed_ops();
		random_ops();
		repeat (3) @(posedge clk);
		#1;
		report_counts();
		if (errors == 0 && prop_fails == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

//--- sim.f
verilog/alu_pkg.sv
verilog/logic_shift_unit.sv
verilog/mul_div_unit.sv
verilog/result_merge.sv
verilog/alu_top.sv
verif/alu_properties.sv
verif/alu_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the ALU testbench with Verilator, runs it into sim.log and checks the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

# Assertion failures must not stop the run, the testbench reports the totals itself
verilator --binary --timing --assert -Wno-fatal --top-module alu_tb -f sim.f -o alu_sim \
	&& ./obj_dir/alu_sim +verilator+error+limit+100000 > sim.log 2>&1 \
	|| { echo "Build or simulation run failed, see sim.log"; exit 1; }

# A run passes only with the pass line present and no assertion error in the log
grep -q "^RESULT: PASS$" sim.log \
	&& ! grep -q "%Error" sim.log \
	&& { echo "Simulation passed"; exit 0; } \
	|| { echo "Simulation failed, see sim.log"; exit 1; }
